// ==== rtl/id_pkg.sv ====
package id_pkg;

   localparam int p_issue_width = 1;
   localparam int iw = 1 << p_issue_width;
   localparam int buf_depth = 8;
   localparam int buf_aw = $clog2(buf_depth);
   localparam int insn_w = 32;
   localparam int pc_w = 32;
   localparam int dw = 32;
   localparam int lrf_aw = 5;

   // Major opcodes
   localparam logic [5:0] op_alu_r = 6'h00;
   localparam logic [5:0] op_addi = 6'h01;
   localparam logic [5:0] op_andi = 6'h02;
   localparam logic [5:0] op_ori = 6'h03;
   localparam logic [5:0] op_lw = 6'h08;
   localparam logic [5:0] op_sw = 6'h09;
   localparam logic [5:0] op_beq = 6'h10;
   localparam logic [5:0] op_jal = 6'h11;
   localparam logic [5:0] op_syscall = 6'h20;

   // Funct field of R-format ALU instructions
   localparam logic [10:0] funct_add = 11'd0;
   localparam logic [10:0] funct_sub = 11'd1;
   localparam logic [10:0] funct_and = 11'd2;
   localparam logic [10:0] funct_or = 11'd3;
   localparam logic [10:0] funct_xor = 11'd4;
   localparam logic [10:0] funct_sll = 11'd5;

   typedef struct packed {
      logic [5:0] opcode;
      logic [lrf_aw-1:0] rd;
      logic [lrf_aw-1:0] rs1;
      logic [lrf_aw-1:0] rs2;
      logic [insn_w-6-3*lrf_aw-1:0] funct;
   } insn_r_t;

   typedef struct packed {
      logic [5:0] opcode;
      logic [lrf_aw-1:0] rd;
      logic [lrf_aw-1:0] rs1;
      logic [insn_w-6-2*lrf_aw-1:0] imm16;
   } insn_i_t;

   // Same word, seen as R-format or I-format
   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_t;

   // One-hot unit opcodes, first field is the MSB
   typedef struct packed {
      logic alu_add;
      logic alu_sub;
      logic alu_and;
      logic alu_or;
      logic alu_xor;
      logic alu_sll;
   } alu_opc_t;

   typedef struct packed {
      logic load;
      logic store;
   } lsu_opc_t;

   typedef struct packed {
      logic beq;
      logic jal;
   } bru_opc_t;

   typedef struct packed {
      logic syscall;
      logic illegal;
      logic fetch_exc;
      logic irq;
   } epu_opc_t;

   typedef struct packed {
      insn_t insn;
      logic [pc_w-1:0] pc;
      logic exc;
   } fe_ent_t;

   typedef struct packed {
      logic valid;
      alu_opc_t alu;
      lsu_opc_t lsu;
      bru_opc_t bru;
      epu_opc_t epu;
      logic [dw-1:0] imm;
      logic [pc_w-1:0] pc;
      logic [lrf_aw-1:0] lrs1;
      logic lrs1_re;
      logic [lrf_aw-1:0] lrs2;
      logic lrs2_re;
      logic [lrf_aw-1:0] lrd;
      logic lrd_we;
   } rn_slot_t;

endpackage

// ==== rtl/popcnt.sv ====
`timescale 1ns/1ps

module popcnt
(
   input logic [id_pkg::iw-1:0] bitmap,
   output logic [id_pkg::p_issue_width:0] count
);
   import id_pkg::*;

   // Sum of set bits
   always_comb
   begin
      count = '0;
      for (int i = 0; i < iw; i++)
      begin
         count = count + (p_issue_width+1)'(bitmap[i]);
      end
   end

endmodule

// ==== rtl/ins_buf.sv ====
`timescale 1ns/1ps

module ins_buf
(
   input logic clk,
   input logic rst,
   input logic flush,
   input logic push_valid,
   input id_pkg::fe_ent_t push_ent,
   output logic full,
   output logic [id_pkg::iw-1:0] id_valid,
   output id_pkg::fe_ent_t [id_pkg::iw-1:0] id_ent,
   input logic [id_pkg::p_issue_width:0] id_pop_cnt
);
   import id_pkg::*;

   fe_ent_t mem [buf_depth];
   logic [buf_aw-1:0] head;
   logic [buf_aw-1:0] tail;
   logic [buf_aw:0] cnt;
   logic push;

   assign full = (cnt == (buf_aw+1)'(buf_depth));

   // Pushes into a full buffer are lost
   assign push = push_valid & ~full;

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[tail] <= push_ent;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (rst | flush)
      begin
         head <= '0;
         tail <= '0;
         cnt <= '0;
      end
      else
      begin
         if (push)
         begin
            tail <= tail + 1'b1;
         end
         // Retire from the head in the same edge as the push
         head <= head + buf_aw'(id_pop_cnt);
         cnt <= cnt + (buf_aw+1)'(push) - (buf_aw+1)'(id_pop_cnt);
      end
   end

   // Two oldest entries, head in slot 0
   always_comb
   begin
      for (int i = 0; i < iw; i++)
      begin
         id_valid[i] = (cnt > i);
         id_ent[i] = mem[head + buf_aw'(i)];
      end
   end

endmodule

// ==== rtl/id_dec.sv ====
`timescale 1ns/1ps

module id_dec
(
   input logic id_valid,
   input id_pkg::fe_ent_t id_ent,
   input logic irq_async,
   output id_pkg::rn_slot_t slot
);
   import id_pkg::*;

   insn_t insn;
   logic [dw-1:0] imm_sext;
   logic [dw-1:0] imm_zext;
   logic legal;

   assign insn = id_ent.insn;
   assign imm_sext = {{(dw-16){insn.i.imm16[15]}}, insn.i.imm16};
   assign imm_zext = {{(dw-16){1'b0}}, insn.i.imm16};

   always_comb
   begin
      slot = '0;
      slot.valid = id_valid;
      slot.pc = id_ent.pc;
      slot.lrs1 = insn.r.rs1;
      slot.lrs2 = insn.r.rs2;
      slot.lrd = insn.r.rd;
      legal = 1'b1;

      case (insn.r.opcode)
         op_alu_r:
         begin
            slot.lrs1_re = 1'b1;
            slot.lrs2_re = 1'b1;
            slot.lrd_we = 1'b1;
            case (insn.r.funct)
               funct_add: slot.alu.alu_add = 1'b1;
               funct_sub: slot.alu.alu_sub = 1'b1;
               funct_and: slot.alu.alu_and = 1'b1;
               funct_or: slot.alu.alu_or = 1'b1;
               funct_xor: slot.alu.alu_xor = 1'b1;
               funct_sll: slot.alu.alu_sll = 1'b1;
               default: legal = 1'b0;
            endcase
         end
         op_addi, op_andi, op_ori:
         begin
            slot.lrs1_re = 1'b1;
            slot.lrd_we = 1'b1;
            slot.alu.alu_add = (insn.i.opcode == op_addi);
            slot.alu.alu_and = (insn.i.opcode == op_andi);
            slot.alu.alu_or = (insn.i.opcode == op_ori);
            // Logical immediates are zero extended
            slot.imm = (insn.i.opcode == op_addi) ? imm_sext : imm_zext;
         end
         op_lw:
         begin
            slot.lsu.load = 1'b1;
            slot.lrs1_re = 1'b1;
            slot.lrd_we = 1'b1;
            slot.imm = imm_sext;
         end
         op_sw, op_beq:
         begin
            slot.lsu.store = (insn.i.opcode == op_sw);
            slot.bru.beq = (insn.i.opcode == op_beq);
            slot.lrs1_re = 1'b1;
            slot.lrs2_re = 1'b1;
            slot.imm = imm_sext;
         end
         op_jal:
         begin
            slot.bru.jal = 1'b1;
            slot.lrd_we = 1'b1;
            slot.imm = imm_sext;
         end
         op_syscall: slot.epu.syscall = 1'b1;
         default: legal = 1'b0;
      endcase

      // r0 is hardwired, writes to it are dropped
      if (slot.lrd == '0)
      begin
         slot.lrd_we = 1'b0;
      end

      // Exceptions in priority order, each one replaces the others
      if (id_valid & irq_async)
      begin
         slot.epu = '0;
         slot.epu.irq = 1'b1;
      end
      else if (id_ent.exc)
      begin
         slot.epu = '0;
         slot.epu.fetch_exc = 1'b1;
      end
      else if (!legal)
      begin
         slot.epu = '0;
         slot.epu.illegal = 1'b1;
      end

      // EPU ops carry no other unit work
      if (slot.epu != '0)
      begin
         slot.alu = '0;
         slot.lsu = '0;
         slot.bru = '0;
         slot.imm = '0;
         slot.lrs1_re = 1'b0;
         slot.lrs2_re = 1'b0;
         slot.lrd_we = 1'b0;
      end
   end

endmodule

// ==== rtl/id.sv ====
`timescale 1ns/1ps

module id
(
   input logic clk,
   input logic rst,
   input logic flush,
   input logic rn_stall_req,
   input logic irq_async,
   input logic [id_pkg::iw-1:0] id_valid,
   input id_pkg::fe_ent_t [id_pkg::iw-1:0] id_ent,
   output logic [id_pkg::p_issue_width:0] id_pop_cnt,
   output id_pkg::rn_slot_t [id_pkg::iw-1:0] rn_slot,
   output logic [id_pkg::p_issue_width:0] rn_push_size
);
   import id_pkg::*;

   logic p_ce;
   rn_slot_t [iw-1:0] dec_slot;
   rn_slot_t [iw-1:0] slot_q;
   logic [iw-1:0] valid_q;

   // Stage advances unless rename stalls
   assign p_ce = ~rn_stall_req;

   for (genvar i = 0; i < iw; i++)
   begin : gen_dec
      id_dec u_dec
      (
         .id_valid (id_valid[i]),
         .id_ent (id_ent[i]),
         .irq_async (irq_async),
         .slot (dec_slot[i])
      );
   end

   // Nothing consumed while stalled
   popcnt u_popcnt
   (
      .bitmap (id_valid & {iw{p_ce}}),
      .count (id_pop_cnt)
   );

   // Control part of the pipeline register, flush wins over stall
   always_ff @(posedge clk)
   begin
      if (rst | flush)
      begin
         valid_q <= '0;
         rn_push_size <= '0;
      end
      else if (p_ce)
      begin
         for (int i = 0; i < iw; i++)
         begin
            valid_q[i] <= dec_slot[i].valid;
         end
         rn_push_size <= id_pop_cnt;
      end
   end

   // Decoded payload
   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         slot_q <= dec_slot;
      end
   end

   always_comb
   begin
      for (int i = 0; i < iw; i++)
      begin
         rn_slot[i] = slot_q[i];
         rn_slot[i].valid = valid_q[i];
      end
   end

endmodule

// ==== rtl/id_top.sv ====
`timescale 1ns/1ps

module id_top
(
   input logic clk,
   input logic rst,
   input logic flush,
   input logic push_valid,
   input id_pkg::fe_ent_t push_ent,
   input logic rn_stall_req,
   input logic irq_async,
   output logic full,
   output id_pkg::rn_slot_t [id_pkg::iw-1:0] rn_slot,
   output logic [id_pkg::p_issue_width:0] rn_push_size
);
   import id_pkg::*;

   logic [iw-1:0] id_valid;
   fe_ent_t [iw-1:0] id_ent;
   logic [p_issue_width:0] id_pop_cnt;

   ins_buf u_buf
   (
      .clk (clk),
      .rst (rst),
      .flush (flush),
      .push_valid (push_valid),
      .push_ent (push_ent),
      .full (full),
      .id_valid (id_valid),
      .id_ent (id_ent),
      .id_pop_cnt (id_pop_cnt)
   );

   id u_id
   (
      .clk (clk),
      .rst (rst),
      .flush (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async (irq_async),
      .id_valid (id_valid),
      .id_ent (id_ent),
      .id_pop_cnt (id_pop_cnt),
      .rn_slot (rn_slot),
      .rn_push_size (rn_push_size)
   );

endmodule

// ==== tests/tb_id.sv ====
`timescale 1ns/1ps

module tb_id;
   import id_pkg::*;

   logic clk;
   logic rst;
   logic flush;
   logic push_valid;
   fe_ent_t push_ent;
   logic rn_stall_req;
   logic irq_async;
   logic full;
   rn_slot_t [iw-1:0] rn_slot;
   logic [p_issue_width:0] rn_push_size;

   string case_name [32];
   logic [31:0] case_insn [32];
   logic case_exc [32];
   rn_slot_t case_exp [32];
   int n_cases = 0;

   // Scoreboard of pushed instructions in program order
   rn_slot_t exp_q [$];
   string name_q [$];

   int errors = 0;
   int n_pass = 0;
   int n_fail = 0;
   int dropped = 0;
   int dual_seen = 0;
   logic [pc_w-1:0] next_pc = 32'h0000_1000;
   logic [31:0] rnd = 32'h7d86a7ac;
   bit loaded = 0;

   id_top DUT
   (
      .clk (clk),
      .rst (rst),
      .flush (flush),
      .push_valid (push_valid),
      .push_ent (push_ent),
      .rn_stall_req (rn_stall_req),
      .irq_async (irq_async),
      .full (full),
      .rn_slot (rn_slot),
      .rn_push_size (rn_push_size)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_field(input string tname, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("FAILED %s %s expected %h actual %h", tname, field, exp, act);
         errors++;
      end
   endtask

   // Register addresses only matter when their enable is set
   task automatic compare_slot(input string tname, input rn_slot_t exp, input rn_slot_t act);
      check_field(tname, "pc", exp.pc, act.pc);
      check_field(tname, "alu", exp.alu, act.alu);
      check_field(tname, "lsu", exp.lsu, act.lsu);
      check_field(tname, "bru", exp.bru, act.bru);
      check_field(tname, "epu", exp.epu, act.epu);
      check_field(tname, "imm", exp.imm, act.imm);
      check_field(tname, "lrs1_re", exp.lrs1_re, act.lrs1_re);
      check_field(tname, "lrs2_re", exp.lrs2_re, act.lrs2_re);
      check_field(tname, "lrd_we", exp.lrd_we, act.lrd_we);
      if (exp.lrs1_re)
         check_field(tname, "lrs1", exp.lrs1, act.lrs1);
      if (exp.lrs2_re)
         check_field(tname, "lrs2", exp.lrs2, act.lrs2);
      if (exp.lrd_we)
         check_field(tname, "lrd", exp.lrd, act.lrd);
   endtask

   task automatic check_outputs();
      int nvalid;
      rn_slot_t exp;
      string tname;
      nvalid = 0;
      for (int i = 0; i < iw; i++)
      begin
         if (rn_slot[i].valid)
         begin
            nvalid++;
            if (exp_q.size() == 0)
            begin
               $display("Slot %0d shows an instruction that is not expected, pc %h",
                        i, rn_slot[i].pc);
               errors++;
            end
            else
            begin
               exp = exp_q.pop_front();
               tname = name_q.pop_front();
               compare_slot(tname, exp, rn_slot[i]);
            end
         end
      end
      check_field("push_size", "rn_push_size", nvalid, rn_push_size);
      assert (rn_slot[0].valid || !rn_slot[1].valid)
      else
      begin
         $display("Slot 1 is valid while slot 0 is not");
         errors++;
      end
      if (rn_push_size == 2)
         dual_seen++;
   endtask

   // Outputs are read mid-cycle, once per register load
   always @(negedge clk)
   begin
      if (loaded)
         check_outputs();
      loaded = !rn_stall_req;
   end

   task automatic load_cases();
      int fd;
      int n;
      string line;
      string nm;
      logic [31:0] w, ex, a, l, b, e, im, s1, r1, s2, r2, d, we;
      fd = $fopen("tests/id_cases.txt", "r");
      if (fd == 0)
         return;
      while (!$feof(fd) && n_cases < 32)
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#")
         begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nm, w, ex, a, l, b, e, im, s1, r1, s2, r2, d, we);
            if (n == 14)
            begin
               case_name[n_cases] = nm;
               case_insn[n_cases] = w;
               case_exc[n_cases] = ex[0];
               case_exp[n_cases] = '0;
               case_exp[n_cases].valid = 1'b1;
               case_exp[n_cases].alu = a[5:0];
               case_exp[n_cases].lsu = l[1:0];
               case_exp[n_cases].bru = b[1:0];
               case_exp[n_cases].epu = e[3:0];
               case_exp[n_cases].imm = im;
               case_exp[n_cases].lrs1 = s1[4:0];
               case_exp[n_cases].lrs1_re = r1[0];
               case_exp[n_cases].lrs2 = s2[4:0];
               case_exp[n_cases].lrs2_re = r2[0];
               case_exp[n_cases].lrd = d[4:0];
               case_exp[n_cases].lrd_we = we[0];
               n_cases++;
            end
         end
      end
      $fclose(fd);
   endtask

   // Called just after a rising edge, returns just after the next one
   task automatic push_case(input int idx, input bit with_irq);
      rn_slot_t exp;
      push_valid = 1'b1;
      push_ent.insn = case_insn[idx];
      push_ent.pc = next_pc;
      push_ent.exc = case_exc[idx];
      if (!full)
      begin
         exp = case_exp[idx];
         if (with_irq)
         begin
            // Interrupt replaces everything but valid and pc
            exp = '0;
            exp.valid = 1'b1;
            exp.epu.irq = 1'b1;
         end
         exp.pc = next_pc;
         exp_q.push_back(exp);
         name_q.push_back(case_name[idx]);
      end
      else
         dropped++;
      next_pc = next_pc + 4;
      @(posedge clk);
      #2;
      push_valid = 1'b0;
   endtask

   task automatic drain(input string tname);
      int n;
      n = 0;
      rn_stall_req = 1'b0;
      while (exp_q.size() != 0 && n < 30)
      begin
         @(posedge clk);
         #2;
         n++;
      end
      assert (exp_q.size() == 0)
      else
      begin
         $display("%s: %0d instructions never left the decode stage", tname, exp_q.size());
         errors++;
      end
   endtask

   task automatic report_test(input string tname, input int err_before);
      if (errors == err_before)
      begin
         $display("test %-14s ok", tname);
         n_pass++;
      end
      else
      begin
         $display("test %-14s FAIL with %0d errors", tname, errors - err_before);
         n_fail++;
      end
   endtask

   initial
   begin
      int e0;
      int d0;
      clk = 1'b0;
      rst = 1'b1;
      flush = 1'b0;
      push_valid = 1'b0;
      push_ent = '0;
      rn_stall_req = 1'b0;
      irq_async = 1'b0;
      load_cases();
      if (n_cases == 0)
      begin
         $display("No cases could be read from tests/id_cases.txt");
         $display("Some tests failed");
         $finish;
      end
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      // Every case on its own
      for (int k = 0; k < n_cases; k++)
      begin
         e0 = errors;
         push_case(k, 1'b0);
         drain(case_name[k]);
         report_test(case_name[k], e0);
      end

      // Two queued entries leave decode in the same cycle
      e0 = errors;
      d0 = dual_seen;
      rn_stall_req = 1'b1;
      push_case(0, 1'b0);
      push_case(10, 1'b0);
      drain("back_to_back");
      assert (dual_seen > d0)
      else
      begin
         $display("back_to_back: both slots were never filled in one cycle");
         errors++;
      end
      report_test("back_to_back", e0);

      // Random stalls, then a long stall that fills the buffer
      e0 = errors;
      for (int k = 0; k < 40; k++)
      begin
         rnd = xorshift(rnd);
         rn_stall_req = rnd[0];
         push_case(k % n_cases, 1'b0);
      end
      rn_stall_req = 1'b1;
      d0 = dropped;
      for (int k = 0; k < 12; k++)
         push_case(k % n_cases, 1'b0);
      assert (full && dropped > d0)
      else
      begin
         $display("random_stall: the buffer did not report full during a long stall");
         errors++;
      end
      drain("random_stall");
      report_test("random_stall", e0);

      // Flush drops everything in flight, even while stalled
      e0 = errors;
      rn_stall_req = 1'b0;
      push_case(0, 1'b0);
      push_case(1, 1'b0);
      // First entry now sits in the pipeline register
      rn_stall_req = 1'b1;
      for (int k = 2; k < 5; k++)
         push_case(k, 1'b0);
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      assert (rn_push_size == 0 && !rn_slot[0].valid && !rn_slot[1].valid)
      else
      begin
         $display("flush: valid bits or push size not cleared after the flush edge");
         errors++;
      end
      exp_q.delete();
      name_q.delete();
      rn_stall_req = 1'b0;
      push_case(3, 1'b0);
      push_case(4, 1'b0);
      drain("flush");
      report_test("flush", e0);

      e0 = errors;
      irq_async = 1'b1;
      push_case(0, 1'b1);
      push_case(11, 1'b1);
      drain("interrupt");
      irq_async = 1'b0;
      report_test("interrupt", e0);

      repeat (3) @(posedge clk);
      $display("Summary: %0d tests ok, %0d tests with errors", n_pass, n_fail);
      if (n_fail == 0 && errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Limit scales with the number of cases
   initial
   begin
      wait (n_cases > 0);
      #((n_cases * 20 + 400) * 40);
      $display("Timeout: the tests did not finish within the time limit");
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== tests/id_cases.txt ====
# name insn exc alu lsu bru epu imm lrs1 lrs1_re lrs2 lrs2_re lrd lrd_we
# all values hex, register addresses are only compared when their enable is set
add_r       00611000 0 20 0 0 0 00000000 01 1 02 1 03 1
sub_r       00853001 0 10 0 0 0 00000000 05 1 06 1 04 1
and_r       00e84802 0 08 0 0 0 00000000 08 1 09 1 07 1
or_r        014b6003 0 04 0 0 0 00000000 0b 1 0c 1 0a 1
xor_r       01ae7804 0 02 0 0 0 00000000 0e 1 0f 1 0d 1
sll_r       03fee805 0 01 0 0 0 00000000 1e 1 1d 1 1f 1
bad_funct   00221806 0 00 0 0 4 00000000 00 0 00 0 00 0
addi_neg    0443fff0 0 20 0 0 0 fffffff0 03 1 00 0 02 1
andi_zext   08a68001 0 08 0 0 0 00008001 06 1 00 0 05 1
ori_zext    0d21f00f 0 04 0 0 0 0000f00f 01 1 00 0 09 1
lw          209d0010 0 00 2 0 0 00000010 1d 1 00 0 04 1
sw          241d2008 0 00 1 0 0 00002008 1d 1 04 1 00 0
beq_back    4001fffc 0 00 0 2 0 fffffffc 01 1 1f 1 00 0
jal         47e00100 0 00 0 1 0 00000100 00 0 00 0 1f 1
syscall     80000000 0 00 0 0 8 00000000 00 0 00 0 00 0
bad_opcode  fc000000 0 00 0 0 4 00000000 00 0 00 0 00 0
add_to_r0   00011000 0 20 0 0 0 00000000 01 1 02 1 00 0
addi_to_r0  04040005 0 20 0 0 0 00000005 04 1 00 0 00 0
fetch_exc   0443fff0 1 00 0 0 2 00000000 00 0 00 0 00 0

// ==== sim.f ====
rtl/id_pkg.sv
rtl/popcnt.sv
rtl/ins_buf.sv
rtl/id_dec.sv
rtl/id.sv
rtl/id_top.sv
tests/tb_id.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - files:
      - rtl/id_pkg.sv
      - rtl/popcnt.sv
      - rtl/ins_buf.sv
      - rtl/id_dec.sv
      - rtl/id.sv
      - rtl/id_top.sv
  - target: test
    files:
      - tests/tb_id.sv
